// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tart_tb
LINT_TOP  ?= tart
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)

run: build
	$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/tart.sv ====
`timescale 1ns/1ps

module tart (
   input  logic                    b_clk,
   input  logic                    reset_i,
   input  logic                    cyc_i,
   input  logic                    stb_i,
   input  logic                    we_i,
   input  tart_bus_pkg::bus_addr_t adr_i,
   input  tart_bus_pkg::bus_data_t dat_i,
   input  tart_viz_pkg::ant_t      ant_i,
   input  logic                    ax_valid_i,
   output tart_bus_pkg::bus_data_t dat_o,
   output logic                    ack_o,
   output logic                    err_o,
   output logic                    led_o
);
   import tart_bus_pkg::*;
   import tart_viz_pkg::*;

   logic      acq_stb, ctrl_stb, acq_ack, ctrl_ack;
   bus_data_t acq_dat, ctrl_dat;
   bus_data_t block_size;
   logic      vx_enable, available, overflow, newblock;
   logic      viz_done, soft_reset, unit_rst;
   pair_idx_t viz_idx;
   accum_t    viz_data, checksum;

   assign unit_rst = reset_i | soft_reset;  // Bus side stays alive

   // ------------------------------
   // Bus decode and register units
   // ------------------------------
   tart_wb_decode u_decode (
      .b_clk, .reset_i, .cyc_i, .stb_i, .adr_i,
      .acq_ack_i(acq_ack), .ctrl_ack_i(ctrl_ack),
      .acq_dat_i(acq_dat), .ctrl_dat_i(ctrl_dat),
      .acq_stb_o(acq_stb), .ctrl_stb_o(ctrl_stb),
      .ack_o, .err_o, .dat_o);

   tart_control u_control (
      .b_clk, .reset_i, .stb_i(ctrl_stb), .we_i, .adr_i(adr_i[1:0]), .dat_i,
      .checksum_i(checksum), .available_i(available), .overflow_i(overflow),
      .vx_enable_i(vx_enable), .ack_o(ctrl_ack), .soft_reset_o(soft_reset),
      .dat_o(ctrl_dat));

   tart_acquire u_acquire (
      .b_clk, .reset_i(unit_rst), .stb_i(acq_stb), .we_i, .adr_i(adr_i[3:0]), .dat_i,
      .viz_data_i(viz_data), .available_i(available), .overflow_i(overflow),
      .ack_o(acq_ack), .dat_o(acq_dat), .vx_enable_o(vx_enable),
      .block_size_o(block_size), .viz_idx_o(viz_idx), .viz_done_o(viz_done));

   tart_correlator u_corr (
      .b_clk, .reset_i(unit_rst), .ant_i, .valid_i(ax_valid_i), .enable_i(vx_enable),
      .block_size_i(block_size), .viz_idx_i(viz_idx), .viz_done_i(viz_done),
      .viz_data_o(viz_data), .checksum_o(checksum), .available_o(available),
      .overflow_o(overflow), .newblock_o(newblock));

   // Blink once per accepted block
   always_ff @(posedge b_clk) begin
      if (reset_i) led_o <= 1'b0;
      else if (newblock) led_o <= ~led_o;
   end

endmodule

// ==== logic/tart_acquire.sv ====
`timescale 1ns/1ps

module tart_acquire (
   input  logic                      b_clk,
   input  logic                      reset_i,
   input  logic                      stb_i,
   input  logic                      we_i,
   input  logic [3:0]                adr_i,
   input  tart_bus_pkg::bus_data_t   dat_i,
   input  tart_viz_pkg::accum_t      viz_data_i,
   input  logic                      available_i,
   input  logic                      overflow_i,
   output logic                      ack_o,
   output tart_bus_pkg::bus_data_t   dat_o,
   output logic                      vx_enable_o,
   output tart_bus_pkg::bus_data_t   block_size_o,
   output tart_viz_pkg::pair_idx_t   viz_idx_o,
   output logic                      viz_done_o
);
   import tart_bus_pkg::*;
   import tart_viz_pkg::*;

   logic access, wr, rd;
   logic wr_ctrl, wr_block;
   logic rd_hi;

   assign access   = stb_i & ~ack_o;
   assign wr       = access & we_i;
   assign rd       = access & ~we_i;
   assign wr_ctrl  = wr & (adr_i == ACQ_CTRL_ADR);
   assign wr_block = wr & (adr_i == ACQ_BLOCK_ADR);
   assign rd_hi    = rd & (adr_i == ACQ_VIZ_HI_ADR) & available_i;  // Moves pointer

   // ------------------------------
   // Control regs and read pointer
   // ------------------------------
   always_ff @(posedge b_clk) begin
      if (reset_i) begin
         ack_o        <= 1'b0;
         vx_enable_o  <= 1'b0;
         block_size_o <= BLOCK_SIZE_RESET;
         viz_idx_o    <= '0;
         viz_done_o   <= 1'b0;
      end else begin
         ack_o      <= access;
         viz_done_o <= 1'b0;
         if (wr_ctrl) vx_enable_o <= dat_i[0];
         if (wr_block) block_size_o <= dat_i;
         if (rd_hi) begin
            if (viz_idx_o == pair_idx_t'(NUM_PAIRS - 1)) begin
               viz_idx_o  <= '0;    // Bank fully read
               viz_done_o <= 1'b1;  // Frees bank in correlator
            end else begin
               viz_idx_o <= viz_idx_o + 1'b1;
            end
         end
      end
   end

   // Read data, registered with ack so pointer moves after capture
   always_ff @(posedge b_clk) begin
      if (access) begin
         case (adr_i)
            ACQ_CTRL_ADR:     dat_o <= {{(BUS_DATA_BITS-1){1'b0}}, vx_enable_o};
            ACQ_BLOCK_ADR:    dat_o <= block_size_o;
            ACQ_VIZ_LO_ADR:   dat_o <= available_i ? viz_data_i[7:0] : '0;
            ACQ_VIZ_HI_ADR:   dat_o <= available_i ? viz_data_i[15:8] : '0;
            ACQ_VIZ_STAT_ADR: dat_o <= {overflow_i, available_i, 3'b000, viz_idx_o};
            default:          dat_o <= '0;
         endcase
      end
   end

   // Host must keep block size nonzero
   a_block_nz : assert property (@(posedge b_clk) disable iff (reset_i)
      wr_block |-> (dat_i != '0));

endmodule

// ==== logic/tart_bus_pkg.sv ====
package tart_bus_pkg;

   // ------------------------------
   // Register bus widths
   // ------------------------------
   localparam int BUS_DATA_BITS = 8;
   localparam int BUS_ADDR_BITS = 7;

   typedef logic [BUS_DATA_BITS-1:0] bus_data_t;
   typedef logic [BUS_ADDR_BITS-1:0] bus_addr_t;

   // Region codes, upper address bits
   localparam logic [2:0] ACQ_REGION  = 3'h0;  // adr[6:4]
   localparam logic [3:0] CTRL_REGION = 4'hf;  // adr[6:3]

   // Acquisition unit offsets
   localparam logic [3:0] ACQ_CTRL_ADR     = 4'h0;  // Bit 0 enables correlator
   localparam logic [3:0] ACQ_BLOCK_ADR    = 4'h1;  // Samples per block
   localparam logic [3:0] ACQ_VIZ_LO_ADR   = 4'h2;
   localparam logic [3:0] ACQ_VIZ_HI_ADR   = 4'h3;  // Read advances pointer
   localparam logic [3:0] ACQ_VIZ_STAT_ADR = 4'h4;  // {ovf, avail, 3'b0, ptr}

   // Control unit offsets
   localparam logic [1:0] CTRL_STATUS_ADR = 2'h0;
   localparam logic [1:0] CTRL_SUM_LO_ADR = 2'h1;
   localparam logic [1:0] CTRL_SUM_HI_ADR = 2'h2;
   localparam logic [1:0] CTRL_RESET_ADR  = 2'h3;  // Write-only

   localparam int        RESET_CYCLES     = 4;
   localparam bus_data_t BLOCK_SIZE_RESET = 8'd8;

endpackage

// ==== logic/tart_control.sv ====
`timescale 1ns/1ps

module tart_control (
   input  logic                    b_clk,
   input  logic                    reset_i,
   input  logic                    stb_i,
   input  logic                    we_i,
   input  logic [1:0]              adr_i,
   input  tart_bus_pkg::bus_data_t dat_i,
   input  tart_viz_pkg::accum_t    checksum_i,
   input  logic                    available_i,
   input  logic                    overflow_i,
   input  logic                    vx_enable_i,
   output logic                    ack_o,
   output logic                    soft_reset_o,
   output tart_bus_pkg::bus_data_t dat_o
);
   import tart_bus_pkg::*;
   import tart_viz_pkg::*;

   typedef enum logic {CTRL_RUN, CTRL_RESET} ctrl_state_t;
   typedef logic [$clog2(RESET_CYCLES)-1:0] rst_cnt_t;

   ctrl_state_t state;
   rst_cnt_t    rst_cnt;
   logic        access;
   logic        start_rst;

   assign access    = stb_i & ~ack_o;  // First strobe cycle
   // Reset write is taken in the ack cycle, soft reset follows
   assign start_rst = ack_o & stb_i & we_i & (adr_i == CTRL_RESET_ADR) & dat_i[0];

   // ------------------------------
   // Software reset sequencer
   // ------------------------------
   always_ff @(posedge b_clk) begin
      if (reset_i) begin
         state   <= CTRL_RUN;
         rst_cnt <= '0;
         ack_o   <= 1'b0;
      end else begin
         ack_o <= access;
         case (state)
            CTRL_RUN: if (start_rst) state <= CTRL_RESET;
            CTRL_RESET: begin  // Repeat writes ignored here
               rst_cnt <= rst_cnt + 1'b1;
               if (rst_cnt == rst_cnt_t'(RESET_CYCLES - 1)) begin
                  rst_cnt <= '0;
                  state   <= CTRL_RUN;
               end
            end
            default: state <= CTRL_RUN;
         endcase
      end
   end

   assign soft_reset_o = (state == CTRL_RESET);

   // Read mux, captured with the ack
   always_ff @(posedge b_clk) begin
      if (access) begin
         case (adr_i)
            CTRL_STATUS_ADR: dat_o <= {{(BUS_DATA_BITS-4){1'b0}}, soft_reset_o,
                                       overflow_i, available_i, vx_enable_i};
            CTRL_SUM_LO_ADR: dat_o <= checksum_i[BUS_DATA_BITS-1:0];
            CTRL_SUM_HI_ADR: dat_o <= checksum_i[ACCUM_BITS-1:BUS_DATA_BITS];
            default:         dat_o <= '0;  // Reset register reads zero
         endcase
      end
   end

   a_rst_len : assert property (@(posedge b_clk) disable iff (reset_i)
      soft_reset_o [*RESET_CYCLES] |=> !soft_reset_o);

endmodule

// ==== logic/tart_correlator.sv ====
`timescale 1ns/1ps

module tart_correlator (
   input  logic                    b_clk,
   input  logic                    reset_i,
   input  tart_viz_pkg::ant_t      ant_i,
   input  logic                    valid_i,
   input  logic                    enable_i,
   input  logic [7:0]              block_size_i,
   input  tart_viz_pkg::pair_idx_t viz_idx_i,
   input  logic                    viz_done_i,
   output tart_viz_pkg::accum_t    viz_data_o,
   output tart_viz_pkg::accum_t    checksum_o,
   output logic                    available_o,
   output logic                    overflow_o,
   output logic                    newblock_o
);
   import tart_viz_pkg::*;

   ant_t                 ant_q;  // Registered sample
   logic                 valid_q;
   logic [NUM_PAIRS-1:0] agree;
   accum_t               acc      [NUM_PAIRS];
   accum_t               acc_next [NUM_PAIRS];
   accum_t               bank     [NUM_PAIRS];  // Read-back copy
   accum_t               sum_next;
   logic [7:0]           count;  // Samples in current block
   logic                 last;
   logic                 load;

   // ------------------------------
   // Input stage
   // ------------------------------
   always_ff @(posedge b_clk) begin
      ant_q <= ant_i;
      if (reset_i) valid_q <= 1'b0;
      else valid_q <= valid_i & enable_i;  // Disabled samples never counted
   end

   // Pair agreement, index follows package pair order
   always_comb begin : pair_agree
      agree = '0;
      for (int a = 0; a < NUM_ANTENNAS - 1; a++) begin
         for (int b = a + 1; b < NUM_ANTENNAS; b++) begin
            agree[a * (2 * NUM_ANTENNAS - a - 1) / 2 + b - a - 1] = (ant_q[a] == ant_q[b]);
         end
      end
   end

   // Next counts and bank checksum
   always_comb begin
      sum_next = '0;
      for (int p = 0; p < NUM_PAIRS; p++) begin
         acc_next[p] = acc[p] + accum_t'(agree[p]);
         sum_next    = sum_next + acc_next[p];  // Wraps at ACCUM_BITS
      end
   end

   assign last = ({1'b0, count} + 9'd1) >= {1'b0, block_size_i};
   assign load = valid_q & last & ~available_o;  // Bank free, take block

   // ------------------------------
   // Accumulate and block end
   // ------------------------------
   always_ff @(posedge b_clk) begin
      if (reset_i) begin
         count       <= '0;
         available_o <= 1'b0;
         overflow_o  <= 1'b0;
         newblock_o  <= 1'b0;
         for (int p = 0; p < NUM_PAIRS; p++) acc[p] <= '0;
      end else begin
         newblock_o <= load;
         if (viz_done_i) available_o <= 1'b0;
         if (load) available_o <= 1'b1;
         if (valid_q && last && available_o) overflow_o <= 1'b1;  // Sticky, block lost
         if (valid_q) begin
            count <= last ? '0 : count + 1'b1;
            for (int p = 0; p < NUM_PAIRS; p++) acc[p] <= last ? '0 : acc_next[p];
         end
      end
   end

   // Bank and checksum capture
   always_ff @(posedge b_clk) begin
      if (load) begin
         checksum_o <= sum_next;
         for (int p = 0; p < NUM_PAIRS; p++) bank[p] <= acc_next[p];
      end
   end

   assign viz_data_o = (viz_idx_i < NUM_PAIRS) ? bank[viz_idx_i] : '0;

   // New block flagged for read-back, bank was free before
   a_no_clobber : assert property (@(posedge b_clk) disable iff (reset_i)
      newblock_o |-> available_o && !$past(available_o));

endmodule

// ==== logic/tart_viz_pkg.sv ====
package tart_viz_pkg;

   // ------------------------------
   // Correlator dimensions
   // ------------------------------
   localparam int NUM_ANTENNAS = 4;
   localparam int NUM_PAIRS    = NUM_ANTENNAS * (NUM_ANTENNAS - 1) / 2;  // 6
   localparam int ACCUM_BITS   = 16;
   localparam int PAIR_BITS    = $clog2(NUM_PAIRS);

   // One-bit sample per antenna
   typedef logic [NUM_ANTENNAS-1:0] ant_t;

   // Agreement count of one pair
   typedef logic [ACCUM_BITS-1:0] accum_t;

   // Pair order
   //   0:(0,1) 1:(0,2) 2:(0,3)
   //   3:(1,2) 4:(1,3) 5:(2,3)
   typedef logic [PAIR_BITS-1:0] pair_idx_t;

endpackage

// ==== logic/tart_wb_decode.sv ====
`timescale 1ns/1ps

module tart_wb_decode (
   input  logic                    b_clk,
   input  logic                    reset_i,
   input  logic                    cyc_i,
   input  logic                    stb_i,
   input  tart_bus_pkg::bus_addr_t adr_i,
   input  logic                    acq_ack_i,
   input  logic                    ctrl_ack_i,
   input  tart_bus_pkg::bus_data_t acq_dat_i,
   input  tart_bus_pkg::bus_data_t ctrl_dat_i,
   output logic                    acq_stb_o,
   output logic                    ctrl_stb_o,
   output logic                    ack_o,
   output logic                    err_o,
   output tart_bus_pkg::bus_data_t dat_o
);
   import tart_bus_pkg::*;

   logic acq_hit, ctrl_hit, miss;
   logic acq_sel, ctrl_sel;  // Unit owning current access

   // Region decode
   assign acq_hit  = (adr_i[BUS_ADDR_BITS-1:4] == ACQ_REGION);
   assign ctrl_hit = (adr_i[BUS_ADDR_BITS-1:3] == CTRL_REGION);
   assign miss     = cyc_i & stb_i & ~acq_hit & ~ctrl_hit;

   assign acq_stb_o  = cyc_i & stb_i & acq_hit;
   assign ctrl_stb_o = cyc_i & stb_i & ctrl_hit;

   // Hold selection until the unit acks, drop on end of cycle
   always_ff @(posedge b_clk) begin
      if (reset_i || !cyc_i) begin
         acq_sel  <= 1'b0;
         ctrl_sel <= 1'b0;
         err_o    <= 1'b0;
      end else begin
         acq_sel  <= acq_stb_o & ~(acq_sel & acq_ack_i);
         ctrl_sel <= ctrl_stb_o & ~(ctrl_sel & ctrl_ack_i);
         err_o    <= miss & ~err_o;  // Unmapped, answered here
      end
   end

   // Response path back to host
   assign ack_o = (acq_sel & acq_ack_i) | (ctrl_sel & ctrl_ack_i);
   assign dat_o = acq_sel ? acq_dat_i : (ctrl_sel ? ctrl_dat_i : '0);

   // Every strobe answered on the next cycle
   a_one_cycle : assert property (@(posedge b_clk) disable iff (reset_i)
      cyc_i && stb_i && !ack_o && !err_o |=> ack_o || err_o);

endmodule

// ==== project.f ====
+incdir+tests
logic/tart_bus_pkg.sv
logic/tart_viz_pkg.sv
logic/tart_wb_decode.sv
logic/tart_control.sv
logic/tart_acquire.sv
logic/tart_correlator.sv
logic/tart.sv
tests/tart_tb.sv

// ==== tests/tart_tb_tasks.svh ====
`ifndef TART_TB_TASKS_SVH
`define TART_TB_TASKS_SVH

// ------------------------------
// Checking helpers
// ------------------------------
task automatic check_value(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
   checks++;
   assert (exp === act) else begin
      errors++;
      $display("** Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
   end
endtask

// One transaction, strobe held until ack or err, dropped on the next cycle
task automatic bus_access(input string name, input logic w, input bus_addr_t a,
                          input bus_data_t d, input logic exp_err, output bus_data_t rd);
   int lat;
   lat = 0;
   @(posedge b_clk);
   #2;
   cyc    = 1'b1;
   stb    = 1'b1;
   we     = w;
   adr    = a;
   dat_wr = d;
   do begin
      @(posedge b_clk);
      lat++;
      @(negedge b_clk);  // Response sampled mid-cycle
   end while (!ack && !err && lat < BUS_TIMEOUT);
   assert (ack || err) else begin
      errors++;
      $display("%s: no bus response within %0d cycles", name, BUS_TIMEOUT);
   end
   if (ack || err) begin
      check_value({name, " response"}, exp_err ? 2 : 1, {err, ack});
      check_value({name, " latency"}, 1, lat);  // One cycle after strobe
   end
   rd = dat_rd;
   @(posedge b_clk);
   #2;
   cyc = 1'b0;
   stb = 1'b0;
   we  = 1'b0;
endtask

task automatic bus_write(input string name, input bus_addr_t a, input bus_data_t d);
   bus_data_t ignored;
   bus_access(name, 1'b1, a, d, 1'b0, ignored);
endtask

task automatic bus_read(input string name, input bus_addr_t a, output bus_data_t d);
   bus_access(name, 1'b0, a, '0, 1'b0, d);
endtask

// Poll status until soft reset bit clears
task automatic wait_reset_done(input string name);
   bus_data_t st;
   int        polls;
   polls = 0;
   do begin
      bus_read({name, " poll"}, A_STATUS, st);
      polls++;
   end while (st[3] && polls < 10);
   assert (!st[3]) else begin
      errors++;
      $display("%s: soft reset still active after %0d status reads", name, polls);
   end
endtask

`endif

// ==== tests/tart_tb.sv ====
`timescale 1ns/1ps

module tart_tb;
   import tart_bus_pkg::*;
   import tart_viz_pkg::*;

   typedef enum {OP_WR, OP_RD, OP_ERR, OP_BLOCK, OP_VIZ, OP_SUM, OP_LED, OP_SRST} op_t;

   localparam int BLOCK_LEN   = 8;
   localparam int NUM_BLOCKS  = 4;
   localparam int BUS_TIMEOUT = 16;  // Cycles allowed for ack or err

   // Address map
   localparam bus_addr_t A_ACQ_CTRL = 7'h00;
   localparam bus_addr_t A_BLOCK    = 7'h01;
   localparam bus_addr_t A_VIZ_LO   = 7'h02;
   localparam bus_addr_t A_VIZ_HI   = 7'h03;
   localparam bus_addr_t A_VIZ_STAT = 7'h04;
   localparam bus_addr_t A_UNMAPPED = 7'h40;
   localparam bus_addr_t A_STATUS   = 7'h78;  // Control region base
   localparam bus_addr_t A_SUM_LO   = 7'h79;
   localparam bus_addr_t A_SUM_HI   = 7'h7a;
   localparam bus_addr_t A_RESET    = 7'h7b;

   // Pair order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   localparam int PAIR_A [NUM_PAIRS] = '{0, 0, 0, 1, 1, 2};
   localparam int PAIR_B [NUM_PAIRS] = '{1, 2, 3, 2, 3, 3};

   logic      b_clk = 1'b0;
   logic      rst, cyc, stb, we, ack, err, led, ax_valid;
   bus_addr_t adr;
   bus_data_t dat_wr, dat_rd;
   ant_t      ant;

   // Stimulus table
   string     step_name [$];
   op_t       step_op   [$];
   bus_addr_t step_adr  [$];
   bus_data_t step_dat  [$];
   bus_data_t step_exp  [$];
   logic      table_built = 1'b0;

   // Reference model state
   ant_t   samples [NUM_BLOCKS*BLOCK_LEN];
   accum_t m_bank  [NUM_PAIRS];
   logic   m_avail = 1'b0;  // Bank holds an unread block
   logic   m_led   = 1'b0;
   int     errors  = 0;
   int     checks  = 0;

   always #20 b_clk = ~b_clk;  // 40 ns period

   tart tart_i (
      .b_clk, .reset_i(rst), .cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr),
      .dat_i(dat_wr), .ant_i(ant), .ax_valid_i(ax_valid), .dat_o(dat_rd),
      .ack_o(ack), .err_o(err), .led_o(led));

   `include "tart_tb_tasks.svh"

   task automatic add_step(input string name, input op_t op, input bus_addr_t a,
                           input bus_data_t d, input bus_data_t exp);
      step_name.push_back(name);
      step_op.push_back(op);
      step_adr.push_back(a);
      step_dat.push_back(d);
      step_exp.push_back(exp);
   endtask

   // ------------------------------
   // Test table
   // ------------------------------
   task automatic build_table();
      add_step("blk_size_wr",  OP_WR,    A_BLOCK,    8'h08, 8'h00);
      add_step("enable_wr",    OP_WR,    A_ACQ_CTRL, 8'h01, 8'h00);
      add_step("blk_size_rd",  OP_RD,    A_BLOCK,    8'h00, 8'h08);
      add_step("enable_rd",    OP_RD,    A_ACQ_CTRL, 8'h00, 8'h01);
      add_step("unmapped",     OP_ERR,   A_UNMAPPED, 8'h00, 8'h00);
      add_step("stat_idle",    OP_RD,    A_VIZ_STAT, 8'h00, 8'h00);
      add_step("block_1",      OP_BLOCK, A_ACQ_CTRL, 8'd0,  8'h00);
      add_step("stat_avail",   OP_RD,    A_VIZ_STAT, 8'h00, 8'h40);
      add_step("sum_1",        OP_SUM,   A_SUM_LO,   8'h00, 8'h00);
      add_step("viz_1",        OP_VIZ,   A_VIZ_LO,   8'h00, 8'h00);
      add_step("led_1",        OP_LED,   A_ACQ_CTRL, 8'h00, 8'h00);
      add_step("stat_done",    OP_RD,    A_VIZ_STAT, 8'h00, 8'h00);
      add_step("block_2",      OP_BLOCK, A_ACQ_CTRL, 8'd1,  8'h00);
      add_step("sum_2",        OP_SUM,   A_SUM_LO,   8'h00, 8'h00);
      add_step("viz_2",        OP_VIZ,   A_VIZ_LO,   8'h00, 8'h00);
      add_step("led_2",        OP_LED,   A_ACQ_CTRL, 8'h00, 8'h00);
      add_step("block_3",      OP_BLOCK, A_ACQ_CTRL, 8'd2,  8'h00);
      add_step("block_4",      OP_BLOCK, A_ACQ_CTRL, 8'd3,  8'h00);  // Dropped
      add_step("stat_ovf",     OP_RD,    A_VIZ_STAT, 8'h00, 8'hc0);
      add_step("viz_3",        OP_VIZ,   A_VIZ_LO,   8'h00, 8'h00);
      add_step("led_3",        OP_LED,   A_ACQ_CTRL, 8'h00, 8'h00);
      add_step("ctrl_status",  OP_RD,    A_STATUS,   8'h00, 8'h05);
      add_step("blk_size_wr2", OP_WR,    A_BLOCK,    8'h0c, 8'h00);
      add_step("soft_reset",   OP_SRST,  A_RESET,    8'h01, 8'h00);
      add_step("enable_rst",   OP_RD,    A_ACQ_CTRL, 8'h00, 8'h00);
      add_step("blk_size_rst", OP_RD,    A_BLOCK,    8'h00, 8'h08);
      add_step("stat_rst",     OP_RD,    A_VIZ_STAT, 8'h00, 8'h00);
      add_step("status_rst",   OP_RD,    A_STATUS,   8'h00, 8'h00);
      add_step("blk_size_wr3", OP_WR,    A_BLOCK,    8'h10, 8'h00);
      add_step("blk_size_rd3", OP_RD,    A_BLOCK,    8'h00, 8'h10);
   endtask

   // Eight valid samples, model counts agreements per pair
   task automatic run_block(input int blk);
      accum_t cnt [NUM_PAIRS];
      ant_t   s;
      foreach (cnt[p]) cnt[p] = '0;
      for (int i = 0; i < BLOCK_LEN; i++) begin
         s = samples[blk*BLOCK_LEN + i];
         @(posedge b_clk);
         #2;
         ant      = s;
         ax_valid = 1'b1;
         for (int p = 0; p < NUM_PAIRS; p++) begin
            if (s[PAIR_A[p]] == s[PAIR_B[p]]) cnt[p]++;
         end
      end
      @(posedge b_clk);
      #2;
      ax_valid = 1'b0;
      repeat (2) @(posedge b_clk);  // Bank loads two cycles after last sample
      if (!m_avail) begin
         m_bank  = cnt;
         m_avail = 1'b1;
         m_led   = ~m_led;
      end
   endtask

   task automatic run_step(input int s);
      bus_data_t lo, hi;
      accum_t    sum;
      case (step_op[s])
         OP_WR:    bus_write(step_name[s], step_adr[s], step_dat[s]);
         OP_RD: begin
            bus_read(step_name[s], step_adr[s], lo);
            check_value(step_name[s], step_exp[s], lo);
         end
         OP_ERR:   bus_access(step_name[s], 1'b0, step_adr[s], '0, 1'b1, lo);
         OP_BLOCK: run_block(step_dat[s]);
         OP_VIZ: begin
            for (int p = 0; p < NUM_PAIRS; p++) begin
               bus_read(step_name[s], A_VIZ_LO, lo);
               bus_read(step_name[s], A_VIZ_HI, hi);  // Advances pointer
               check_value($sformatf("%s pair %0d", step_name[s], p),
                           m_avail ? m_bank[p] : '0, {hi, lo});
            end
            m_avail = 1'b0;
         end
         OP_SUM: begin
            sum = '0;
            foreach (m_bank[p]) sum += m_bank[p];  // Wraps at 16 bits
            bus_read(step_name[s], A_SUM_LO, lo);
            bus_read(step_name[s], A_SUM_HI, hi);
            check_value(step_name[s], sum, {hi, lo});
         end
         OP_LED:   check_value(step_name[s], m_led, led);
         OP_SRST: begin
            bus_write(step_name[s], step_adr[s], step_dat[s]);
            wait_reset_done(step_name[s]);
            m_avail = 1'b0;  // Bank flags cleared
         end
         default: ;
      endcase
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      rst      = 1'b1;
      cyc      = 1'b0;
      stb      = 1'b0;
      we       = 1'b0;
      adr      = '0;
      dat_wr   = '0;
      ant      = '0;
      ax_valid = 1'b0;
      void'($urandom(32'hc51f_1c9a));
      foreach (samples[i]) samples[i] = ant_t'($urandom);
      foreach (m_bank[p]) m_bank[p] = '0;
      build_table();
      table_built = 1'b1;
      repeat (16) @(posedge b_clk);
      #2;
      rst = 1'b0;
      for (int s = 0; s < step_name.size(); s++) run_step(s);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // Watchdog, 300 cycles per table entry
   initial begin
      wait (table_built);
      repeat (step_name.size() * 300) @(posedge b_clk);
      $display("Watchdog expired, the test table did not complete in time");
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule
